/* armCore_settings.svh */
`ifndef ARM_CORE_SETTINGS_SVH
`define ARM_CORE_SETTINGS_SVH

// Datapath and instruction widths
`define ARM_DATA_WIDTH 64
`define ARM_INSTR_WIDTH 32

// Register index width and the hardwired zero register
`define ARM_REG_SEL_WIDTH 5
`define ARM_ZERO_REG 31

// Byte step between sequential instructions
`define ARM_PC_STEP 4

`endif

/* armCorePkg.sv */
`include "armCore_settings.svh"

package armCorePkg;

    typedef logic [`ARM_DATA_WIDTH-1:0] dataWord_t;
    typedef logic [`ARM_INSTR_WIDTH-1:0] instrWord_t;
    typedef logic [`ARM_REG_SEL_WIDTH-1:0] regSel_t;

    // Top opcode bits, instruction[31:26]
    typedef enum logic [5:0] {
        R_FORMAT = 6'b001010,
        I_FORMAT = 6'b100010
    } formatCode_e;

    // R-format function, instruction[25:21]
    typedef enum logic [4:0] {
        R_ADD  = 5'b00000,
        R_AND  = 5'b00010,
        R_EOR  = 5'b00100,
        R_ENOR = 5'b00101,
        R_LSL  = 5'b00110,
        R_LSR  = 5'b00111,
        R_ORR  = 5'b01000,
        R_SUB  = 5'b01001
    } rFunct_e;

    // I-format function, instruction[25:22]
    typedef enum logic [3:0] {
        ADDI  = 4'b0000,
        ANDI  = 4'b0010,
        EORI  = 4'b0100,
        ENORI = 4'b0101,
        ORRI  = 4'b0110,
        SUBI  = 4'b0111
    } iFunct_e;

    // ALU select codes, low half goes through the carry cells
    typedef enum logic [2:0] {
        ALU_EOR  = 3'b000,
        ALU_ENOR = 3'b001,
        ALU_ADD  = 3'b010,
        ALU_SUB  = 3'b011,
        ALU_ORR  = 3'b100,
        ALU_LSL  = 3'b101,
        ALU_AND  = 3'b110,
        ALU_LSR  = 3'b111
    } aluOp_e;

endpackage

/* armCoreIf.sv */
`timescale 1ns/1ns

// Decoded instruction bundle between decode and execute
interface decodedIf;

    armCorePkg::aluOp_e    aluOp;
    armCorePkg::dataWord_t immValue;
    logic                  useImm;
    armCorePkg::regSel_t   dest;
    logic                  writeEnable;

    modport decoder (
        output aluOp,
        output immValue,
        output useImm,
        output dest,
        output writeEnable
    );

    modport execute (
        input aluOp,
        input immValue,
        input useImm,
        input dest,
        input writeEnable
    );

endinterface

/* instrFetch.sv */
`timescale 1ns/1ns
`include "armCore_settings.svh"

module instrFetch (
    input  logic                   clk,
    input  logic                   reset,
    input  armCorePkg::instrWord_t ibus,
    output armCorePkg::dataWord_t  iaddrbus,
    output armCorePkg::instrWord_t instrWord,
    output logic                   instrValid
);

    // Program counter, one instruction per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            iaddrbus <= '0;
        end
        else
        begin
            iaddrbus <= iaddrbus + `ARM_DATA_WIDTH'(`ARM_PC_STEP);
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            instrValid <= 1'b0;
        end
        else
        begin
            instrValid <= 1'b1;
        end
        instrWord <= ibus;
    end

endmodule

/* opDecoder.sv */
`timescale 1ns/1ns
`include "armCore_settings.svh"

module opDecoder (
    input  armCorePkg::instrWord_t instrWord,
    input  logic                   instrValid,
    decodedIf.decoder              dec
);

    armCorePkg::formatCode_e formatCode;
    armCorePkg::rFunct_e     rFunct;
    armCorePkg::iFunct_e     iFunct;
    armCorePkg::dataWord_t   shiftImm;
    armCorePkg::dataWord_t   signedImm;
    logic                    supported;

    assign formatCode = armCorePkg::formatCode_e'(instrWord[31:26]);
    assign rFunct     = armCorePkg::rFunct_e'(instrWord[25:21]);
    assign iFunct     = armCorePkg::iFunct_e'(instrWord[25:22]);

    // Shift amount zero-extended, ALU immediate sign-extended
    assign shiftImm  = `ARM_DATA_WIDTH'(instrWord[15:10]);
    assign signedImm = {{(`ARM_DATA_WIDTH - 12){instrWord[21]}}, instrWord[21:10]};

    always_comb
    begin
        supported    = 1'b1;
        dec.aluOp    = armCorePkg::ALU_EOR;
        dec.useImm   = 1'b0;
        dec.immValue = signedImm;
        case (formatCode)
            armCorePkg::R_FORMAT:
            begin
                case (rFunct)
                    armCorePkg::R_ADD:  dec.aluOp = armCorePkg::ALU_ADD;
                    armCorePkg::R_SUB:  dec.aluOp = armCorePkg::ALU_SUB;
                    armCorePkg::R_AND:  dec.aluOp = armCorePkg::ALU_AND;
                    armCorePkg::R_ORR:  dec.aluOp = armCorePkg::ALU_ORR;
                    armCorePkg::R_EOR:  dec.aluOp = armCorePkg::ALU_EOR;
                    armCorePkg::R_ENOR: dec.aluOp = armCorePkg::ALU_ENOR;
                    armCorePkg::R_LSL, armCorePkg::R_LSR:
                    begin
                        // Operand B becomes the shift amount
                        dec.aluOp    = (rFunct == armCorePkg::R_LSL) ?
                                       armCorePkg::ALU_LSL : armCorePkg::ALU_LSR;
                        dec.useImm   = 1'b1;
                        dec.immValue = shiftImm;
                    end
                    default: supported = 1'b0;
                endcase
            end
            armCorePkg::I_FORMAT:
            begin
                dec.useImm = 1'b1;
                case (iFunct)
                    armCorePkg::ADDI:  dec.aluOp = armCorePkg::ALU_ADD;
                    armCorePkg::SUBI:  dec.aluOp = armCorePkg::ALU_SUB;
                    armCorePkg::ANDI:  dec.aluOp = armCorePkg::ALU_AND;
                    armCorePkg::ORRI:  dec.aluOp = armCorePkg::ALU_ORR;
                    armCorePkg::EORI:  dec.aluOp = armCorePkg::ALU_EOR;
                    armCorePkg::ENORI: dec.aluOp = armCorePkg::ALU_ENOR;
                    default: supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    assign dec.dest = instrWord[4:0];

    // Nothing reaches the zero register
    assign dec.writeEnable = instrValid && supported &&
                             (instrWord[4:0] != `ARM_REG_SEL_WIDTH'(`ARM_ZERO_REG));

endmodule

/* regFile.sv */
`timescale 1ns/1ns
`include "armCore_settings.svh"

module regFile (
    input  logic                   clk,
    input  armCorePkg::instrWord_t instrWord,
    input  logic                   wbEnable,
    input  armCorePkg::regSel_t    wbSelect,
    input  armCorePkg::dataWord_t  wbData,
    output armCorePkg::dataWord_t  aData,
    output armCorePkg::dataWord_t  bData
);

    // Storage for X0..X30, index 31 has no storage
    armCorePkg::dataWord_t regs [0:`ARM_ZERO_REG-1];

    armCorePkg::regSel_t rnSel;
    armCorePkg::regSel_t rmSel;

    assign rnSel = instrWord[9:5];
    assign rmSel = instrWord[20:16];

    always_comb
    begin
        aData = '0;
        bData = '0;
        if (rnSel != `ARM_REG_SEL_WIDTH'(`ARM_ZERO_REG))
        begin
            aData = regs[rnSel];
        end
        if (rmSel != `ARM_REG_SEL_WIDTH'(`ARM_ZERO_REG))
        begin
            bData = regs[rmSel];
        end
    end

    // Decoder never raises a write for index 31
    always_ff @(posedge clk)
    begin
        if (wbEnable)
        begin
            regs[wbSelect] <= wbData;
        end
    end

endmodule

/* aluExecute.sv */
`timescale 1ns/1ns
`include "armCore_settings.svh"

module aluExecute (
    input  logic                  clk,
    input  logic                  reset,
    decodedIf.execute             dec,
    input  armCorePkg::dataWord_t aData,
    input  armCorePkg::dataWord_t bData,
    output logic                  wbEnable,
    output armCorePkg::regSel_t   wbSelect,
    output armCorePkg::dataWord_t wbData
);

    localparam int dataWidth = `ARM_DATA_WIDTH;
    localparam int shiftBits = $clog2(dataWidth);

    // Decode/execute register contents
    logic                  exValid;
    armCorePkg::aluOp_e    exAluOp;
    armCorePkg::dataWord_t exImm;
    logic                  exUseImm;
    armCorePkg::regSel_t   exDest;
    armCorePkg::dataWord_t exA;
    armCorePkg::dataWord_t exB;

    armCorePkg::dataWord_t opB;
    armCorePkg::dataWord_t bMod;
    armCorePkg::dataWord_t genBit;
    armCorePkg::dataWord_t propBit;
    armCorePkg::dataWord_t carryBit;
    armCorePkg::dataWord_t result;
    logic                  invertB;
    logic                  carryIn;

    // Heap-ordered tree nodes, node 1 is the root, leaves start at dataWidth
    wire [2*dataWidth-1:1] gNode;
    wire [2*dataWidth-1:1] pNode;
    wire [2*dataWidth-1:1] cNode;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            exValid <= 1'b0;
        end
        else
        begin
            exValid <= dec.writeEnable;
        end
        exAluOp  <= dec.aluOp;
        exImm    <= dec.immValue;
        exUseImm <= dec.useImm;
        exDest   <= dec.dest;
        exA      <= aData;
        exB      <= bData;
    end

    assign opB = exUseImm ? exImm : exB;

    // ENOR and SUB work on the inverted B operand
    assign invertB = (exAluOp == armCorePkg::ALU_ENOR) || (exAluOp == armCorePkg::ALU_SUB);
    assign carryIn = (exAluOp == armCorePkg::ALU_SUB);
    assign bMod    = opB ^ {dataWidth{invertB}};
    assign genBit  = exA & bMod;
    assign propBit = exA ^ bMod;

    // Lookahead-carry tree
    assign gNode[2*dataWidth-1:dataWidth] = genBit;
    assign pNode[2*dataWidth-1:dataWidth] = propBit;
    assign cNode[1] = carryIn;

    for (genvar n = 1; n < dataWidth; n++)
    begin : lacNode
        assign gNode[n] = gNode[2*n+1] | (pNode[2*n+1] & gNode[2*n]);
        assign pNode[n] = pNode[2*n+1] & pNode[2*n];
        assign cNode[2*n] = cNode[n];
        assign cNode[2*n+1] = gNode[2*n] | (pNode[2*n] & cNode[n]);
    end

    assign carryBit = cNode[2*dataWidth-1:dataWidth];

    always_comb
    begin
        case (exAluOp)
            armCorePkg::ALU_EOR, armCorePkg::ALU_ENOR: result = propBit;
            armCorePkg::ALU_ADD, armCorePkg::ALU_SUB:  result = propBit ^ carryBit;
            armCorePkg::ALU_ORR: result = exA | opB;
            armCorePkg::ALU_AND: result = exA & opB;
            armCorePkg::ALU_LSL: result = exA << opB[shiftBits-1:0];
            armCorePkg::ALU_LSR: result = exA >> opB[shiftBits-1:0];
            default: result = propBit;
        endcase
    end

    // Execute/write-back register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wbEnable <= 1'b0;
        end
        else
        begin
            wbEnable <= exValid;
        end
        wbSelect <= exDest;
        wbData   <= result;
    end

endmodule

/* armCore.sv */
`timescale 1ns/1ns
`include "armCore_settings.svh"

module armCore (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`ARM_INSTR_WIDTH-1:0]   ibus,
    output logic [`ARM_DATA_WIDTH-1:0]    iaddrbus,
    output logic                          wbEnable,
    output logic [`ARM_REG_SEL_WIDTH-1:0] wbSelect,
    output logic [`ARM_DATA_WIDTH-1:0]    wbData
);

    armCorePkg::instrWord_t instrWord;
    logic                   instrValid;
    armCorePkg::dataWord_t  aData;
    armCorePkg::dataWord_t  bData;

    decodedIf decoded ();

    instrFetch u_instrFetch (
        .clk        (clk),
        .reset      (reset),
        .ibus       (ibus),
        .iaddrbus   (iaddrbus),
        .instrWord  (instrWord),
        .instrValid (instrValid)
    );

    // Decoder and register file both read the fetched word
    opDecoder u_opDecoder (
        .instrWord  (instrWord),
        .instrValid (instrValid),
        .dec        (decoded.decoder)
    );

    regFile u_regFile (
        .clk       (clk),
        .instrWord (instrWord),
        .wbEnable  (wbEnable),
        .wbSelect  (wbSelect),
        .wbData    (wbData),
        .aData     (aData),
        .bData     (bData)
    );

    aluExecute u_aluExecute (
        .clk      (clk),
        .reset    (reset),
        .dec      (decoded.execute),
        .aData    (aData),
        .bData    (bData),
        .wbEnable (wbEnable),
        .wbSelect (wbSelect),
        .wbData   (wbData)
    );

endmodule

/* armCore_properties.sv */
`timescale 1ns/1ns
`include "armCore_settings.svh"

module armCore_properties (
    input logic                          clk,
    input logic                          reset,
    input logic [`ARM_DATA_WIDTH-1:0]    iaddrbus,
    input logic                          wbEnable,
    input logic [`ARM_REG_SEL_WIDTH-1:0] wbSelect
);

    // Write-back enable comes straight from reset-cleared valid bits
    wbEnableKnown: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(wbEnable)
    ) else $error("wbEnable is unknown after reset");

    // One instruction fetched per cycle
    pcStep: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> iaddrbus == $past(iaddrbus) + `ARM_DATA_WIDTH'(`ARM_PC_STEP)
    ) else $error("iaddrbus did not step by the fetch increment");

    noZeroRegWrite: assert property (
        @(posedge clk) disable iff (reset)
        wbEnable |-> wbSelect != `ARM_REG_SEL_WIDTH'(`ARM_ZERO_REG)
    ) else $error("write-back selects the zero register");

endmodule

/* tb_armCore.sv */
`timescale 1ns/1ns

module tb_armCore;

    localparam armCorePkg::instrWord_t bubbleWord = 32'hFFFF_FFFF;
    // Instructions issued by all tests including the final drain
    localparam int issueCount = 6*5 + 6*2*4 + 3 + 2*64 + 6 + 7 + 3;

    logic                   clk;
    logic                   reset;
    armCorePkg::instrWord_t ibus;
    armCorePkg::dataWord_t  iaddrbus;
    logic                   wbEnable;
    armCorePkg::regSel_t    wbSelect;
    armCorePkg::dataWord_t  wbData;

    integer                 seed;
    armCorePkg::dataWord_t  pcExpect;
    armCorePkg::dataWord_t  model [0:31];
    logic                   expEn [$];
    armCorePkg::regSel_t    expSel [$];
    armCorePkg::dataWord_t  expData [$];

    armCore u_dut (
        .clk      (clk),
        .reset    (reset),
        .ibus     (ibus),
        .iaddrbus (iaddrbus),
        .wbEnable (wbEnable),
        .wbSelect (wbSelect),
        .wbData   (wbData)
    );

    bind armCore armCore_properties u_props (
        .clk      (clk),
        .reset    (reset),
        .iaddrbus (iaddrbus),
        .wbEnable (wbEnable),
        .wbSelect (wbSelect)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        #(100 * (issueCount + 50));
        $display("Timeout: the tests did not finish in the expected time");
        stopOnFailure();
    end

    task automatic stopOnFailure();
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic checkData(input string name, input armCorePkg::dataWord_t exp,
                             input armCorePkg::dataWord_t act);
        if (exp !== act)
        begin
            $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
            stopOnFailure();
        end
    endtask

    task automatic checkSelect(input string name, input armCorePkg::regSel_t exp,
                               input armCorePkg::regSel_t act);
        if (exp !== act)
        begin
            $display("ERR time=%0t signal=%s expected=%0d actual=%0d", $time, name, exp, act);
            stopOnFailure();
        end
    endtask

    task automatic checkEnable(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("ERR time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
            stopOnFailure();
        end
    endtask

    function automatic armCorePkg::instrWord_t encodeR(input armCorePkg::rFunct_e f,
        input armCorePkg::regSel_t rd, input armCorePkg::regSel_t rn,
        input armCorePkg::regSel_t rm, input logic [5:0] shamt);
        return {armCorePkg::R_FORMAT, f, rm, shamt, rn, rd};
    endfunction

    function automatic armCorePkg::instrWord_t encodeI(input armCorePkg::iFunct_e f,
        input armCorePkg::regSel_t rd, input armCorePkg::regSel_t rn, input logic [11:0] imm);
        return {armCorePkg::I_FORMAT, f, imm, rn, rd};
    endfunction

    // Expected write-back of one instruction against the model registers
    function automatic void predict(input armCorePkg::instrWord_t w, output logic en,
        output armCorePkg::regSel_t sel, output armCorePkg::dataWord_t val);
        armCorePkg::dataWord_t a;
        armCorePkg::dataWord_t b;
        armCorePkg::dataWord_t imm;
        logic                  ok;
        a   = model[w[9:5]];
        b   = model[w[20:16]];
        imm = {{52{w[21]}}, w[21:10]};
        ok  = 1'b1;
        val = '0;
        if (w[31:26] == armCorePkg::R_FORMAT)
        begin
            case (w[25:21])
                armCorePkg::R_ADD:  val = a + b;
                armCorePkg::R_SUB:  val = a - b;
                armCorePkg::R_AND:  val = a & b;
                armCorePkg::R_ORR:  val = a | b;
                armCorePkg::R_EOR:  val = a ^ b;
                armCorePkg::R_ENOR: val = ~(a ^ b);
                armCorePkg::R_LSL:  val = a << w[15:10];
                armCorePkg::R_LSR:  val = a >> w[15:10];
                default: ok = 1'b0;
            endcase
        end
        else if (w[31:26] == armCorePkg::I_FORMAT)
        begin
            case (w[25:22])
                armCorePkg::ADDI:  val = a + imm;
                armCorePkg::SUBI:  val = a - imm;
                armCorePkg::ANDI:  val = a & imm;
                armCorePkg::ORRI:  val = a | imm;
                armCorePkg::EORI:  val = a ^ imm;
                armCorePkg::ENORI: val = ~(a ^ imm);
                default: ok = 1'b0;
            endcase
        end
        else
        begin
            ok = 1'b0;
        end
        sel = w[4:0];
        en  = ok && (sel != 5'd31);
    endfunction

    // One issue slot; checks the result of the instruction three slots back
    task automatic issue(input armCorePkg::instrWord_t instr);
        logic                  en;
        armCorePkg::regSel_t   sel;
        armCorePkg::dataWord_t val;
        @(posedge clk);
        ibus <= instr;
        // Oldest in flight is written into the register file at the next edge
        if (expEn[0])
        begin
            model[expSel[0]] = expData[0];
        end
        predict(instr, en, sel, val);
        expEn.push_back(en);
        expSel.push_back(sel);
        expData.push_back(val);
        @(negedge clk);
        pcExpect = pcExpect + 64'd4;
        checkData("iaddrbus", pcExpect, iaddrbus);
        checkEnable("wbEnable", expEn[0], wbEnable);
        if (expEn[0])
        begin
            checkSelect("wbSelect", expSel[0], wbSelect);
            checkData("wbData", expData[0], wbData);
        end
        void'(expEn.pop_front());
        void'(expSel.pop_front());
        void'(expData.pop_front());
    endtask

    task automatic bubbles(input int n);
        repeat (n) issue(bubbleWord);
    endtask

    task automatic loadReg(input armCorePkg::regSel_t rd, input logic [11:0] imm);
        issue(encodeI(armCorePkg::ADDI, rd, 5'd31, imm));
    endtask

    task automatic testRFormat();
        armCorePkg::rFunct_e ops [6];
        ops = '{armCorePkg::R_ADD, armCorePkg::R_SUB, armCorePkg::R_AND,
                armCorePkg::R_ORR, armCorePkg::R_EOR, armCorePkg::R_ENOR};
        foreach (ops[i])
        begin
            loadReg(5'd1, 12'($random(seed)));
            loadReg(5'd2, 12'($random(seed)));
            bubbles(2);
            issue(encodeR(ops[i], 5'd3, 5'd1, 5'd2, 6'd0));
        end
    endtask

    task automatic testIFormat();
        armCorePkg::iFunct_e ops [6];
        logic [11:0]         imm;
        ops = '{armCorePkg::ADDI, armCorePkg::SUBI, armCorePkg::ANDI,
                armCorePkg::ORRI, armCorePkg::EORI, armCorePkg::ENORI};
        foreach (ops[i])
        begin
            for (int neg = 0; neg < 2; neg++)
            begin
                loadReg(5'd4, 12'($random(seed)));
                bubbles(2);
                imm     = 12'($random(seed));
                imm[11] = (neg == 1);
                issue(encodeI(ops[i], 5'd5, 5'd4, imm));
            end
        end
    endtask

    task automatic testShifts();
        // Negative source so LSR shows the upper bits
        loadReg(5'd6, 12'($random(seed)) | 12'h800);
        bubbles(2);
        for (int sh = 0; sh < 64; sh++)
        begin
            issue(encodeR(armCorePkg::R_LSL, 5'd7, 5'd6, 5'd31, 6'(sh)));
            issue(encodeR(armCorePkg::R_LSR, 5'd8, 5'd6, 5'd31, 6'(sh)));
        end
    endtask

    task automatic testZeroReg();
        loadReg(5'd9, 12'd5);
        issue(encodeR(armCorePkg::R_ORR, 5'd10, 5'd31, 5'd6, 6'd0));
        issue(encodeI(armCorePkg::ADDI, 5'd31, 5'd6, 12'd7));
        bubbles(2);
        // Zero register still reads zero after the discarded write
        issue(encodeR(armCorePkg::R_ADD, 5'd11, 5'd31, 5'd9, 6'd0));
    endtask

    task automatic testBackToBack();
        loadReg(5'd12, 12'($random(seed)));
        loadReg(5'd13, 12'($random(seed)));
        bubbles(2);
        issue(encodeR(armCorePkg::R_ADD, 5'd14, 5'd12, 5'd13, 6'd0));
        // Immediate reader still gets the previous r12
        loadReg(5'd12, 12'($random(seed)));
        issue(encodeR(armCorePkg::R_ADD, 5'd15, 5'd12, 5'd13, 6'd0));
    endtask

    initial
    begin
        seed     = 79009;
        reset    = 1'b1;
        ibus     = bubbleWord;
        pcExpect = '0;
        for (int i = 0; i < 32; i++)
        begin
            model[i] = '0;
        end
        // Pipeline slots still empty at the first issue
        repeat (3)
        begin
            expEn.push_back(1'b0);
            expSel.push_back('0);
            expData.push_back('0);
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkData("iaddrbus", '0, iaddrbus);
        checkEnable("wbEnable", 1'b0, wbEnable);
        testRFormat();
        testIFormat();
        testShifts();
        testZeroReg();
        testBackToBack();
        bubbles(3);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* armCore.f */
+incdir+.
armCorePkg.sv
armCoreIf.sv
instrFetch.sv
opDecoder.sv
regFile.sv
aluExecute.sv
armCore.sv
armCore_properties.sv
tb_armCore.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_armCore
FILELIST  = armCore.f
OBJDIR    = obj_dir
PASS_MSG  = RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
